// File: vlog.f
+incdir+logic
logic/rvseed_pkg.sv
logic/if_stage.sv
logic/id_stage.sv
logic/ex_stage.sv
logic/mem_stage.sv
logic/wb_stage.sv
logic/rvseed_top.sv
bench/tb_clock.sv
bench/rvseed_monitor.sv
bench/rvseed_checker.sv
bench/rvseed_tb.sv

// File: bench/rvseed_tb.sv
// testbench top with program table, instruction responder, test loop and watchdog
`timescale 1ns/10ps
`include "rvseed_settings.svh"

module rvseed_tb;

    typedef struct packed {
        logic [7:0]                  test;
        logic [31:0]                 inst;
        logic                        retires;  // low for rows a taken jump skips
        logic                        wen;
        logic [`REG_ADDR_WIDTH-1:0]  rd;
        logic [`CPU_WIDTH-1:0]       value;
    } row_t;

    localparam logic [31:0] rand_seed     = 32'h05914cee;
    localparam logic [31:0] nop_word      = 32'h0000_0013;  // addi x0, x0, 0
    localparam logic [31:0] ebreak_word   = 32'h0010_0073;
    localparam logic [6:0]  opcode_imm    = 7'b0010011;
    localparam logic [6:0]  opcode_reg    = 7'b0110011;
    localparam logic [6:0]  opcode_lui    = 7'b0110111;
    localparam logic [6:0]  opcode_load   = 7'b0000011;
    localparam logic [6:0]  opcode_store  = 7'b0100011;
    localparam logic [6:0]  opcode_branch = 7'b1100011;
    localparam logic [6:0]  opcode_jal    = 7'b1101111;

    logic                        clk;
    logic                        rst_n;
    logic [31:0]                 inst;
    logic [`CPU_WIDTH-1:0]       pc;
    logic                        retire_valid;
    logic [`CPU_WIDTH-1:0]       retire_pc;
    logic                        retire_wen;
    logic [`REG_ADDR_WIDTH-1:0]  retire_rd;
    logic [`CPU_WIDTH-1:0]       retire_data;
    logic                        ebreak;
    int                          tests_done;
    int                          mon_errors;
    int                          n_tests;
    logic                        table_ready = 1'b0;
    row_t                        rows [$];

    tb_clock u_clock (.clk_o(clk), .rst_n_o(rst_n));

    rvseed_top dut_i (
        .clk(clk), .rst_n_i(rst_n), .inst_i(inst), .pc_o(pc),
        .retire_valid_o(retire_valid), .retire_pc_o(retire_pc),
        .retire_wen_o(retire_wen), .retire_rd_o(retire_rd),
        .retire_data_o(retire_data), .ebreak_o(ebreak)
    );

    rvseed_monitor u_monitor (
        .clk(clk), .rst_n_i(rst_n), .retire_valid_i(retire_valid),
        .retire_pc_i(retire_pc), .retire_wen_i(retire_wen), .retire_rd_i(retire_rd),
        .retire_data_i(retire_data), .ebreak_i(ebreak),
        .tests_done_o(tests_done), .errors_o(mon_errors)
    );

    function automatic logic [31:0] itype(int imm, int rs1, int f3, int rd, logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] rtype(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opcode_reg};
    endfunction

    function automatic logic [31:0] stype(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b011, imm[4:0], opcode_store};
    endfunction

    function automatic logic [31:0] btype(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                opcode_branch};
    endfunction

    function automatic logic [31:0] jtype(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opcode_jal};
    endfunction

    function automatic logic [31:0] utype(logic [19:0] imm, int rd);
        return {imm, rd[4:0], opcode_lui};
    endfunction

    function automatic logic [`CPU_WIDTH-1:0] sext12(logic [11:0] v);
        return {{(`CPU_WIDTH-12){v[11]}}, v};
    endfunction

    function automatic logic [`CPU_WIDTH-1:0] signed_less(logic [`CPU_WIDTH-1:0] x,
                                                          logic [`CPU_WIDTH-1:0] y);
        return ($signed(x) < $signed(y)) ? 64'd1 : 64'd0;
    endfunction

    task automatic reg_write_row(input int test, input logic [31:0] word, input int rd,
                                 input logic [`CPU_WIDTH-1:0] value);
        rows.push_back('{test: test[7:0], inst: word, retires: 1'b1, wen: 1'b1,
                         rd: rd[4:0], value: value});
    endtask

    task automatic silent_row(input int test, input logic [31:0] word);
        rows.push_back('{test: test[7:0], inst: word, retires: 1'b1, wen: 1'b0,
                         rd: '0, value: '0});
    endtask

    task automatic skipped_row(input int test, input logic [31:0] word);
        rows.push_back('{test: test[7:0], inst: word, retires: 1'b0, wen: 1'b0,
                         rd: '0, value: '0});
    endtask

    task automatic build_program();
        logic [31:0]           rnd;
        logic [11:0]           ia;
        logic [11:0]           ib;
        logic [19:0]           iu;
        logic [`CPU_WIDTH-1:0] a;
        logic [`CPU_WIDTH-1:0] b;
        rnd = $urandom(rand_seed);  // seeds the generator
        rnd = $urandom();
        ia  = rnd[11:0];
        rnd = $urandom();
        ib  = rnd[11:0];
        rnd = $urandom();
        iu  = rnd[19:0];
        a   = sext12(ia);
        b   = sext12(ib);
        // test 1 runs alu ops on random immediates in rows 0 to 14
        reg_write_row(1, itype(ia, 0, 0, 1, opcode_imm), 1, a);
        reg_write_row(1, itype(ib, 0, 0, 2, opcode_imm), 2, b);
        reg_write_row(1, rtype(7'h00, 2, 1, 0, 3), 3, a + b);
        reg_write_row(1, rtype(7'h20, 2, 1, 0, 4), 4, a - b);
        reg_write_row(1, rtype(7'h00, 2, 1, 7, 5), 5, a & b);
        reg_write_row(1, rtype(7'h00, 2, 1, 6, 6), 6, a | b);
        reg_write_row(1, rtype(7'h00, 2, 1, 4, 7), 7, a ^ b);
        reg_write_row(1, rtype(7'h00, 2, 1, 2, 8), 8, signed_less(a, b));
        reg_write_row(1, rtype(7'h00, 1, 2, 2, 9), 9, signed_less(b, a));
        reg_write_row(1, utype(iu, 10), 10, 64'($signed({iu, 12'h000})));
        reg_write_row(1, itype(ib, 1, 4, 11, opcode_imm), 11, a ^ b);
        reg_write_row(1, itype(ia, 2, 7, 12, opcode_imm), 12, b & a);
        reg_write_row(1, itype(ib, 1, 6, 13, opcode_imm), 13, a | b);
        reg_write_row(1, itype(ib, 1, 2, 14, opcode_imm), 14, signed_less(a, b));
        silent_row(1, ebreak_word);
        // test 2 is a forwarding chain in rows 15 to 21
        reg_write_row(2, itype(5, 0, 0, 1, opcode_imm), 1, 64'd5);
        reg_write_row(2, itype(3, 1, 0, 2, opcode_imm), 2, 64'd8);    // from execute
        reg_write_row(2, rtype(7'h00, 1, 2, 0, 3), 3, 64'd13);       // execute and memory
        reg_write_row(2, rtype(7'h00, 3, 1, 0, 4), 4, 64'd18);       // x1 from writeback
        reg_write_row(2, rtype(7'h20, 2, 4, 0, 5), 5, 64'd10);
        reg_write_row(2, rtype(7'h00, 3, 5, 4, 6), 6, 64'd7);
        silent_row(2, ebreak_word);
        // test 3 has sd and ld round trips with load-use stalls in rows 22 to 30
        reg_write_row(3, itype(12'h123, 0, 0, 1, opcode_imm), 1, 64'h123);
        reg_write_row(3, itype(64, 0, 0, 2, opcode_imm), 2, 64'd64);
        silent_row(3, stype(8, 1, 2));
        reg_write_row(3, itype(8, 2, 3, 3, opcode_load), 3, 64'h123);
        reg_write_row(3, itype(1, 3, 0, 4, opcode_imm), 4, 64'h124);  // stalls on x3
        silent_row(3, stype(0, 4, 2));
        reg_write_row(3, itype(0, 2, 3, 5, opcode_load), 5, 64'h124);
        reg_write_row(3, rtype(7'h00, 3, 5, 0, 6), 6, 64'h247);       // stalls on x5
        silent_row(3, ebreak_word);
        // test 4 has a taken beq then a not taken bne then a jal in rows 31 to 42
        reg_write_row(4, itype(7, 0, 0, 1, opcode_imm), 1, 64'd7);
        reg_write_row(4, itype(7, 0, 0, 2, opcode_imm), 2, 64'd7);
        silent_row(4, btype(12, 2, 1, 0));                            // to row 36
        skipped_row(4, itype(1, 0, 0, 3, opcode_imm));
        skipped_row(4, itype(2, 0, 0, 3, opcode_imm));
        silent_row(4, btype(8, 2, 1, 1));
        reg_write_row(4, itype(9, 0, 0, 4, opcode_imm), 4, 64'd9);
        reg_write_row(4, jtype(12, 5), 5, 64'd156);                   // pc 152 plus 4
        skipped_row(4, itype(1, 0, 0, 4, opcode_imm));
        skipped_row(4, itype(2, 0, 0, 4, opcode_imm));
        reg_write_row(4, rtype(7'h00, 5, 4, 0, 6), 6, 64'd165);
        silent_row(4, ebreak_word);
        // test 5 drops writes to x0 in rows 43 to 47
        silent_row(5, itype(55, 0, 0, 0, opcode_imm));
        silent_row(5, rtype(7'h00, 2, 1, 0, 0));
        reg_write_row(5, rtype(7'h00, 0, 0, 0, 7), 7, 64'd0);
        reg_write_row(5, itype(3, 0, 0, 8, opcode_imm), 8, 64'd3);
        silent_row(5, ebreak_word);
        n_tests = 5;
    endtask

    // instruction memory model indexed by the word address of the fetch pc
    always @(negedge clk) begin : respond
        int slot;
        slot = int'(pc[33:2]);
        if (slot < rows.size()) inst = rows[slot].inst;
        else                    inst = nop_word;
    end

    initial begin : main
        inst = nop_word;
        build_program();
        foreach (rows[i]) begin
            if (rows[i].retires) begin
                u_monitor.push_expect(rows[i].test, 64'(i) << 2, rows[i].wen, rows[i].rd,
                                      rows[i].value, rows[i].inst == ebreak_word);
            end
        end
        table_ready = 1'b1;
        wait (rst_n);
        for (int t = 1; t <= n_tests; t++) begin
            wait (tests_done >= t);
        end
        repeat (2) @(negedge clk);
        if (mon_errors == 0 && dut_i.u_checker.fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("assertion failures in the checker: %0d", dut_i.u_checker.fail_count);
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        wait (table_ready);
        repeat (rows.size() * 8 + 16) @(posedge clk);
        $display("timeout: the tests did not all finish within %0d cycles",
                 rows.size() * 8 + 16);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: bench/rvseed_checker.sv
// concurrent assertions on the pipeline top level, bound into rvseed_top
`timescale 1ns/10ps
`include "rvseed_settings.svh"

module rvseed_checker (
    input logic                        clk,
    input logic                        rst_n_i,
    input logic [`CPU_WIDTH-1:0]       pc_i,
    input logic                        retire_valid_i,
    input logic                        retire_wen_i,
    input logic [`REG_ADDR_WIDTH-1:0]  retire_rd_i,
    input logic                        ebreak_i
);
    int fail_count = 0;  // read by the testbench at the end

    quiet_in_reset: assert property (@(posedge clk) !rst_n_i |-> !retire_valid_i)
        else begin
            fail_count++;
            $error("an instruction retired while reset was asserted");
        end

    no_x0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
                                  retire_valid_i && retire_wen_i |-> retire_rd_i != '0)
        else begin
            fail_count++;
            $error("a retirement wrote register x0");
        end

    pc_aligned: assert property (@(posedge clk) disable iff (!rst_n_i) pc_i[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("fetch pc is not word aligned");
        end

    ebreak_retires: assert property (@(posedge clk) disable iff (!rst_n_i)
                                     ebreak_i |-> retire_valid_i)
        else begin
            fail_count++;
            $error("ebreak_o rose without a retirement");
        end

endmodule

bind rvseed_top rvseed_checker u_checker (
    .clk(clk), .rst_n_i(rst_n_i), .pc_i(pc_o),
    .retire_valid_i(retire_valid_o), .retire_wen_i(retire_wen_o),
    .retire_rd_i(retire_rd_o), .ebreak_i(ebreak_o)
);

// File: bench/rvseed_monitor.sv
// retirement monitor comparing the pipeline against the expected program order
`timescale 1ns/10ps
`include "rvseed_settings.svh"

module rvseed_monitor (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        retire_valid_i,
    input  logic [`CPU_WIDTH-1:0]       retire_pc_i,
    input  logic                        retire_wen_i,
    input  logic [`REG_ADDR_WIDTH-1:0]  retire_rd_i,
    input  logic [`CPU_WIDTH-1:0]       retire_data_i,
    input  logic                        ebreak_i,
    output int                          tests_done_o,
    output int                          errors_o
);
    typedef struct packed {
        logic [7:0]                  test;
        logic [`CPU_WIDTH-1:0]       pc;
        logic                        wen;
        logic [`REG_ADDR_WIDTH-1:0]  rd;
        logic [`CPU_WIDTH-1:0]       data;
        logic                        ebreak;
    } expect_t;

    expect_t pending [$];      // retirements still to come in program order
    int      checked = 0;
    int      test_errors = 0;
    int      error_count = 0;
    int      tests_done = 0;

    assign tests_done_o = tests_done;
    assign errors_o     = error_count;

    task automatic push_expect(input logic [7:0] test, input logic [`CPU_WIDTH-1:0] pc,
                               input logic wen, input logic [`REG_ADDR_WIDTH-1:0] rd,
                               input logic [`CPU_WIDTH-1:0] data, input logic ebreak);
        pending.push_back('{test: test, pc: pc, wen: wen, rd: rd, data: data, ebreak: ebreak});
    endtask

    task automatic report_mismatch(input string name, input logic [`CPU_WIDTH-1:0] got,
                                   input logic [`CPU_WIDTH-1:0] want);
        $display("MISMATCH t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, want);
        test_errors++;
        error_count++;
    endtask

    // one retirement per cycle checked mid-cycle
    always @(negedge clk) begin : watch
        expect_t e;
        if (rst_n_i && retire_valid_i) begin
            if (pending.size() == 0) begin
                if (retire_wen_i) begin
                    $display("error at t=%0t: a register write retired after the last test",
                             $time);
                    error_count++;
                end
            end else begin
                e = pending.pop_front();
                checked++;
                if (retire_pc_i != e.pc) report_mismatch("retire_pc_o", retire_pc_i, e.pc);
                if (retire_wen_i != e.wen) begin
                    report_mismatch("retire_wen_o", 64'(retire_wen_i), 64'(e.wen));
                end else if (e.wen) begin
                    if (retire_rd_i != e.rd) begin
                        report_mismatch("retire_rd_o", 64'(retire_rd_i), 64'(e.rd));
                    end
                    if (retire_data_i != e.data) begin
                        report_mismatch("retire_data_o", retire_data_i, e.data);
                    end
                end
                if (ebreak_i != e.ebreak) begin
                    report_mismatch("ebreak_o", 64'(ebreak_i), 64'(e.ebreak));
                end
                if (e.ebreak) begin
                    $display("test %0d finished with %0d errors", e.test, test_errors);
                    tests_done++;
                    test_errors = 0;
                    if (pending.size() == 0) begin
                        $display("summary: %0d tests, %0d retirements checked, %0d errors",
                                 tests_done, checked, error_count);
                    end
                end
            end
        end
    end

endmodule

// File: bench/tb_clock.sv
// clock and reset generator for the pipeline testbench
`timescale 1ns/10ps

module tb_clock (
    output logic clk_o,
    output logic rst_n_o
);
    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        repeat (16) @(negedge clk_o);  // 16 cycles of reset
        rst_n_o = 1'b1;
    end

    always #20 clk_o = ~clk_o;         // 40 ns period

endmodule

// File: logic/rvseed_top.sv
// top level of the five-stage rv64i pipeline
`timescale 1ns/10ps
`include "rvseed_settings.svh"

module rvseed_top (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic [31:0]                 inst_i,
    output logic [`CPU_WIDTH-1:0]       pc_o,
    output logic                        retire_valid_o,
    output logic [`CPU_WIDTH-1:0]       retire_pc_o,
    output logic                        retire_wen_o,
    output logic [`REG_ADDR_WIDTH-1:0]  retire_rd_o,
    output logic [`CPU_WIDTH-1:0]       retire_data_o,
    output logic                        ebreak_o
);
    import rvseed_pkg::*;

    if_id_t                fd;
    id_ex_t                de;
    ex_mem_t               em;
    mem_wb_t               mw;
    fwd_t                  ex_fwd;
    fwd_t                  mem_fwd;
    fwd_t                  wb_fwd;
    logic                  stall;
    logic                  redirect;
    logic [`CPU_WIDTH-1:0] target;
    logic [`CPU_WIDTH-1:0] regs [0:`REG_DATA_DEPTH-1];  // register file read bus

    if_stage u_if_stage (
        .clk(clk), .rst_n_i(rst_n_i), .inst_i(inst_i),
        .stall_i(stall), .redirect_i(redirect), .target_i(target),
        .pc_o(pc_o), .fd_o(fd)
    );

    id_stage u_id_stage (
        .clk(clk), .rst_n_i(rst_n_i), .fd_i(fd), .regs_i(regs),
        .ex_fwd_i(ex_fwd), .mem_fwd_i(mem_fwd), .wb_fwd_i(wb_fwd),
        .de_o(de), .stall_o(stall), .redirect_o(redirect), .target_o(target)
    );

    ex_stage u_ex_stage (
        .clk(clk), .rst_n_i(rst_n_i), .de_i(de),
        .em_o(em), .ex_fwd_o(ex_fwd)
    );

    mem_stage u_mem_stage (
        .clk(clk), .rst_n_i(rst_n_i), .em_i(em),
        .mw_o(mw), .mem_fwd_o(mem_fwd)
    );

    wb_stage u_wb_stage (
        .clk(clk), .rst_n_i(rst_n_i), .mw_i(mw),
        .regs_o(regs), .wb_fwd_o(wb_fwd),
        .retire_valid_o(retire_valid_o), .retire_pc_o(retire_pc_o),
        .retire_wen_o(retire_wen_o), .retire_rd_o(retire_rd_o),
        .retire_data_o(retire_data_o), .ebreak_o(ebreak_o)
    );

endmodule

// File: logic/wb_stage.sv
// register file, writeback forward and retirement outputs
`timescale 1ns/10ps
`include "rvseed_settings.svh"

module wb_stage (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  rvseed_pkg::mem_wb_t         mw_i,
    output logic [`CPU_WIDTH-1:0]       regs_o [0:`REG_DATA_DEPTH-1],
    output rvseed_pkg::fwd_t            wb_fwd_o,
    output logic                        retire_valid_o,
    output logic [`CPU_WIDTH-1:0]       retire_pc_o,
    output logic                        retire_wen_o,
    output logic [`REG_ADDR_WIDTH-1:0]  retire_rd_o,
    output logic [`CPU_WIDTH-1:0]       retire_data_o,
    output logic                        ebreak_o
);
    import rvseed_pkg::*;

    logic [`CPU_WIDTH-1:0] rf [1:`REG_DATA_DEPTH-1];  // x0 has no storage

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < `REG_DATA_DEPTH; i++) rf[i] <= '0;
        end else if (mw_i.valid && mw_i.reg_wen && mw_i.rd != '0) begin
            rf[mw_i.rd] <= mw_i.wdata;
        end
    end

    assign regs_o[0] = '0;
    for (genvar g = 1; g < `REG_DATA_DEPTH; g++) begin : g_rd
        assign regs_o[g] = rf[g];
    end

    // same-cycle bypass for decode
    assign wb_fwd_o = '{valid: mw_i.valid, reg_wen: mw_i.reg_wen, rd: mw_i.rd,
                        data: mw_i.wdata, is_load: 1'b0};

    assign retire_valid_o = mw_i.valid;
    assign retire_pc_o    = mw_i.pc;
    assign retire_wen_o   = mw_i.reg_wen;
    assign retire_rd_o    = mw_i.rd;
    assign retire_data_o  = mw_i.wdata;
    assign ebreak_o       = mw_i.valid && mw_i.ebreak;

endmodule

// File: logic/mem_stage.sv
// data RAM and mem/wb register
`timescale 1ns/10ps
`include "rvseed_settings.svh"

module mem_stage (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  rvseed_pkg::ex_mem_t  em_i,
    output rvseed_pkg::mem_wb_t  mw_o,
    output rvseed_pkg::fwd_t     mem_fwd_o
);
    import rvseed_pkg::*;

    logic [`CPU_WIDTH-1:0]       dmem [0:`DMEM_DEPTH-1];
    logic [`DMEM_ADDR_WIDTH-1:0] dmem_idx;
    logic [`CPU_WIDTH-1:0]       load_data;
    logic [`CPU_WIDTH-1:0]       wdata;

    assign dmem_idx  = em_i.alu_res[`DMEM_ADDR_WIDTH+2:3];  // doubleword index
    assign load_data = dmem[dmem_idx];                      // async read

    always_ff @(posedge clk) begin
        if (em_i.valid && em_i.mem_op == mem_store) begin
            dmem[dmem_idx] <= em_i.store_data;
        end
    end

    assign wdata = (em_i.mem_op == mem_load) ? load_data : em_i.alu_res;

    // load data is known here
    assign mem_fwd_o = '{valid: em_i.valid, reg_wen: em_i.reg_wen, rd: em_i.rd,
                         data: wdata, is_load: 1'b0};

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mw_o <= '0;
        end else begin
            mw_o <= '{valid: em_i.valid, pc: em_i.pc, wdata: wdata,
                      reg_wen: em_i.reg_wen, rd: em_i.rd, ebreak: em_i.ebreak};
        end
    end

endmodule

// File: logic/ex_stage.sv
// ALU and ex/mem register
`timescale 1ns/10ps
`include "rvseed_settings.svh"

module ex_stage (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  rvseed_pkg::id_ex_t   de_i,
    output rvseed_pkg::ex_mem_t  em_o,
    output rvseed_pkg::fwd_t     ex_fwd_o
);
    import rvseed_pkg::*;

    logic [`CPU_WIDTH-1:0] alu_res;
    logic                  lt_signed;

    assign lt_signed = $signed(de_i.op_a) < $signed(de_i.op_b);

    always_comb begin
        case (de_i.alu_op)
            alu_sub:    alu_res = de_i.op_a - de_i.op_b;
            alu_and:    alu_res = de_i.op_a & de_i.op_b;
            alu_or:     alu_res = de_i.op_a | de_i.op_b;
            alu_xor:    alu_res = de_i.op_a ^ de_i.op_b;
            alu_slt:    alu_res = {{(`CPU_WIDTH-1){1'b0}}, lt_signed};
            alu_pass_b: alu_res = de_i.op_b;            // lui, jal link
            default:    alu_res = de_i.op_a + de_i.op_b; // also ld/sd address
        endcase
    end

    assign ex_fwd_o = '{valid: de_i.valid, reg_wen: de_i.reg_wen, rd: de_i.rd,
                        data: alu_res, is_load: de_i.mem_op == mem_load};

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            em_o <= '0;
        end else begin
            em_o <= '{valid: de_i.valid, pc: de_i.pc, alu_res: alu_res,
                      store_data: de_i.store_data, mem_op: de_i.mem_op,
                      reg_wen: de_i.reg_wen, rd: de_i.rd, ebreak: de_i.ebreak};
        end
    end

endmodule

// File: logic/id_stage.sv
// decoder with operand forwarding, branch resolution, load-use stall and id/ex register
`timescale 1ns/10ps
`include "rvseed_settings.svh"

module id_stage (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  rvseed_pkg::if_id_t     fd_i,
    input  logic [`CPU_WIDTH-1:0]  regs_i [0:`REG_DATA_DEPTH-1],
    input  rvseed_pkg::fwd_t       ex_fwd_i,
    input  rvseed_pkg::fwd_t       mem_fwd_i,
    input  rvseed_pkg::fwd_t       wb_fwd_i,
    output rvseed_pkg::id_ex_t     de_o,
    output logic                   stall_o,
    output logic                   redirect_o,
    output logic [`CPU_WIDTH-1:0]  target_o
);
    import rvseed_pkg::*;

    logic [31:0]                 inst;
    rv_opcode_e                  opcode;
    logic [2:0]                  funct3;
    logic [`REG_ADDR_WIDTH-1:0]  rs1;
    logic [`REG_ADDR_WIDTH-1:0]  rs2;
    logic [`REG_ADDR_WIDTH-1:0]  rd;
    logic [`CPU_WIDTH-1:0]       imm_i;
    logic [`CPU_WIDTH-1:0]       imm_s;
    logic [`CPU_WIDTH-1:0]       imm_b;
    logic [`CPU_WIDTH-1:0]       imm_j;
    logic [`CPU_WIDTH-1:0]       imm_u;
    logic [`CPU_WIDTH-1:0]       rs1_val;
    logic [`CPU_WIDTH-1:0]       rs2_val;
    logic                        uses_rs1;
    logic                        uses_rs2;
    logic                        taken;
    logic                        is_write;
    id_ex_t                      de_d;

    function automatic logic fwd_hit(input fwd_t src, input logic [`REG_ADDR_WIDTH-1:0] rs);
        return src.valid && src.reg_wen && (src.rd == rs) && (rs != '0);
    endfunction

    // nearest writer wins
    function automatic logic [`CPU_WIDTH-1:0] fwd_sel(
        input logic [`REG_ADDR_WIDTH-1:0] rs,
        input logic [`CPU_WIDTH-1:0]      rf_val,
        input fwd_t                       ex_src,
        input fwd_t                       mem_src,
        input fwd_t                       wb_src
    );
        if (fwd_hit(ex_src, rs))  return ex_src.data;
        if (fwd_hit(mem_src, rs)) return mem_src.data;
        if (fwd_hit(wb_src, rs))  return wb_src.data;
        return rf_val;
    endfunction

    function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000:  return sub ? alu_sub : alu_add;
            3'b010:  return alu_slt;
            3'b100:  return alu_xor;
            3'b110:  return alu_or;
            3'b111:  return alu_and;
            default: return alu_add;
        endcase
    endfunction

    assign inst   = fd_i.inst;
    assign opcode = rv_opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign rd     = inst[11:7];

    assign imm_i = {{(`CPU_WIDTH-12){inst[31]}}, inst[31:20]};
    assign imm_s = {{(`CPU_WIDTH-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{(`CPU_WIDTH-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{(`CPU_WIDTH-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_u = {{(`CPU_WIDTH-32){inst[31]}}, inst[31:12], 12'b0};

    assign rs1_val = fwd_sel(rs1, regs_i[rs1], ex_fwd_i, mem_fwd_i, wb_fwd_i);
    assign rs2_val = fwd_sel(rs2, regs_i[rs2], ex_fwd_i, mem_fwd_i, wb_fwd_i);

    always_comb begin
        de_d            = '0;
        de_d.pc         = fd_i.pc;
        de_d.alu_op     = alu_add;
        de_d.op_a       = rs1_val;
        de_d.op_b       = imm_i;
        de_d.store_data = rs2_val;
        de_d.mem_op     = mem_none;
        de_d.rd         = rd;
        is_write        = 1'b0;
        uses_rs1        = 1'b0;
        uses_rs2        = 1'b0;
        taken           = 1'b0;
        target_o        = fd_i.pc + imm_b;
        case (opcode)
            opc_op_imm: begin
                uses_rs1    = 1'b1;
                is_write    = 1'b1;
                de_d.alu_op = alu_from_f3(funct3, 1'b0);
            end
            opc_op: begin
                uses_rs1    = 1'b1;
                uses_rs2    = 1'b1;
                is_write    = 1'b1;
                de_d.op_b   = rs2_val;
                de_d.alu_op = alu_from_f3(funct3, inst[30]);
            end
            opc_lui: begin
                is_write    = 1'b1;
                de_d.alu_op = alu_pass_b;
                de_d.op_b   = imm_u;
            end
            opc_load: begin
                uses_rs1    = 1'b1;
                is_write    = 1'b1;
                de_d.mem_op = mem_load;       // ld only
            end
            opc_store: begin
                uses_rs1    = 1'b1;
                uses_rs2    = 1'b1;
                de_d.op_b   = imm_s;
                de_d.mem_op = mem_store;      // sd only
            end
            opc_branch: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                taken    = (funct3 == 3'b000) ? (rs1_val == rs2_val) :
                           (funct3 == 3'b001) ? (rs1_val != rs2_val) : 1'b0;
            end
            opc_jal: begin
                taken       = 1'b1;
                is_write    = 1'b1;
                target_o    = fd_i.pc + imm_j;
                de_d.alu_op = alu_pass_b;
                de_d.op_b   = fd_i.pc + 'd4;  // link value
            end
            opc_system: de_d.ebreak = (inst == 32'h0010_0073);
            default: ;
        endcase
        de_d.reg_wen = is_write && (rd != '0);
    end

    // dependent on a load still in execute
    assign stall_o = fd_i.valid && ex_fwd_i.is_load &&
                     ((uses_rs1 && fwd_hit(ex_fwd_i, rs1)) ||
                      (uses_rs2 && fwd_hit(ex_fwd_i, rs2)));
    assign redirect_o = fd_i.valid && !stall_o && taken;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            de_o <= '0;
        end else begin
            de_o       <= de_d;
            de_o.valid <= fd_i.valid && !stall_o;  // bubble on stall
        end
    end

endmodule

// File: logic/if_stage.sv
// fetch stage with pc register, next-pc select and if/id register
`timescale 1ns/10ps
`include "rvseed_settings.svh"

module if_stage (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic [31:0]            inst_i,
    input  logic                   stall_i,
    input  logic                   redirect_i,
    input  logic [`CPU_WIDTH-1:0]  target_i,
    output logic [`CPU_WIDTH-1:0]  pc_o,
    output rvseed_pkg::if_id_t     fd_o
);
    import rvseed_pkg::*;

    logic [`CPU_WIDTH-1:0] pc_next;

    always_comb begin
        if (redirect_i)   pc_next = target_i;   // taken branch or jal
        else if (stall_i) pc_next = pc_o;       // load-use hold
        else              pc_next = pc_o + 'd4;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_o <= '0;
            fd_o <= '0;
        end else begin
            pc_o <= pc_next;
            if (redirect_i) fd_o.valid <= 1'b0;  // squash the slot behind the jump
            else if (!stall_i) fd_o <= '{valid: 1'b1, pc: pc_o, inst: inst_i};
        end
    end

endmodule

// File: logic/rvseed_pkg.sv
// opcode enums and pipeline register structs for the rv64i pipeline
`include "rvseed_settings.svh"

package rvseed_pkg;

    typedef enum logic [6:0] {
        opc_load   = 7'b0000011,
        opc_op_imm = 7'b0010011,
        opc_store  = 7'b0100011,
        opc_op     = 7'b0110011,
        opc_lui    = 7'b0110111,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_system = 7'b1110011
    } rv_opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b              // result is op_b unchanged
    } alu_op_e;

    typedef enum logic [1:0] {
        mem_none,
        mem_load,
        mem_store
    } mem_op_e;

    typedef struct packed {
        logic                        valid;
        logic [`CPU_WIDTH-1:0]       pc;
        logic [31:0]                 inst;
    } if_id_t;

    typedef struct packed {
        logic                        valid;
        logic [`CPU_WIDTH-1:0]       pc;
        alu_op_e                     alu_op;
        logic [`CPU_WIDTH-1:0]       op_a;
        logic [`CPU_WIDTH-1:0]       op_b;
        logic [`CPU_WIDTH-1:0]       store_data;
        mem_op_e                     mem_op;
        logic                        reg_wen;
        logic [`REG_ADDR_WIDTH-1:0]  rd;
        logic                        ebreak;
    } id_ex_t;

    typedef struct packed {
        logic                        valid;
        logic [`CPU_WIDTH-1:0]       pc;
        logic [`CPU_WIDTH-1:0]       alu_res;
        logic [`CPU_WIDTH-1:0]       store_data;
        mem_op_e                     mem_op;
        logic                        reg_wen;
        logic [`REG_ADDR_WIDTH-1:0]  rd;
        logic                        ebreak;
    } ex_mem_t;

    typedef struct packed {
        logic                        valid;
        logic [`CPU_WIDTH-1:0]       pc;
        logic [`CPU_WIDTH-1:0]       wdata;
        logic                        reg_wen;
        logic [`REG_ADDR_WIDTH-1:0]  rd;
        logic                        ebreak;
    } mem_wb_t;

    typedef struct packed {
        logic                        valid;
        logic                        reg_wen;
        logic [`REG_ADDR_WIDTH-1:0]  rd;
        logic [`CPU_WIDTH-1:0]       data;
        logic                        is_load;  // data is still an address
    } fwd_t;

endpackage

// File: logic/rvseed_settings.svh
// width and depth macros for the rv64i pipeline
`ifndef RVSEED_SETTINGS_SVH
`define RVSEED_SETTINGS_SVH

// data path
`define CPU_WIDTH        64

// register file
`define REG_ADDR_WIDTH   5
`define REG_DATA_DEPTH   32

// data RAM indexed by address bits 8 down to 3
`define DMEM_DEPTH       64
`define DMEM_ADDR_WIDTH  6

`endif
